// ==== dv/tb_cache_top.sv ====
`timescale 1ns/100ps

module tb_cache_top;

    localparam int WAYS   = 2;
    localparam int STALLS = 3;   // Largest random rsp_ready stall

    typedef struct packed {
        cache_pkg::cache_op_e            op;
        logic [cache_pkg::ADDR_BITS-1:0] addr;
        logic [cache_pkg::DATA_BITS-1:0] wdata;
        logic [1:0]                      stall;  // Cycles rsp_ready stays low
    } stim_t;

    logic                  clk;
    logic                  rst;
    logic                  cmd_valid;
    cache_pkg::cache_cmd_t cmd;
    logic                  cmd_ready;
    logic                  rsp_valid;
    cache_pkg::cache_rsp_t rsp;
    logic                  rsp_ready;

    stim_t                           stim_q[$];
    logic [cache_pkg::ADDR_BITS-1:0] written_q[$];  // Addresses with known data
    logic                            table_ready;

    // Reference model of memory values and cache state
    logic [cache_pkg::DATA_BITS-1:0] shadow [int];
    logic                            m_valid [cache_pkg::SETS][WAYS];
    logic                            m_dirty [cache_pkg::SETS][WAYS];
    logic [cache_pkg::TAG_BITS-1:0]  m_tag   [cache_pkg::SETS][WAYS];
    int                              m_rank  [cache_pkg::SETS][WAYS];
    logic                            exp_wb;   // Last miss evicts a dirty line

    cache_top #(.WAYS(WAYS)) UUT (
        .clk, .rst,
        .cmd_valid, .cmd, .cmd_ready,
        .rsp_valid, .rsp, .rsp_ready
    );

    always #50 clk = ~clk;   // 100 ns period

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_rsp(string name, cache_pkg::cache_rsp_t exp,
                             cache_pkg::cache_rsp_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected hit=%0b rdata=%h, actual hit=%0b rdata=%h",
                     $time, name, exp.hit, exp.rdata, act.hit, act.rdata);
            stop_run();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_latency(string name, int exp, int act);
        if (act != exp) begin
            $display("FAILED at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_min_latency(string name, int min_exp, int act);
        if (act < min_exp) begin
            $display("FAILED at %0t: %s expected at least %0d, actual %0d",
                     $time, name, min_exp, act);
            stop_run();
        end
    endtask

    task automatic check_idle();
        check_bit("cmd_ready", 1'b1, cmd_ready);
        check_bit("rsp_valid", 1'b0, rsp_valid);
    endtask

    function automatic logic [cache_pkg::ADDR_BITS-1:0] make_addr(logic [7:0] tag,
                                                                  logic [3:0] index,
                                                                  logic [1:0] offset);
        return {tag, index, offset};  // Tag on top, word offset at the bottom
    endfunction

    // Touched way goes to the top, higher ranks move down one
    function automatic void touch_line(int s, int w);
        int r;
        r = m_rank[s][w];
        for (int i = 0; i < WAYS; i++) begin
            if (i == w) begin
                m_rank[s][i] = WAYS - 1;
            end else if (m_rank[s][i] > r) begin
                m_rank[s][i] = m_rank[s][i] - 1;
            end
        end
    endfunction

    // Steps the model by one command and gives the expected result
    function automatic cache_pkg::cache_rsp_t predict(stim_t e);
        cache_pkg::cache_rsp_t exp;
        int                    s;
        int                    way;
        logic [7:0]            tag;
        exp    = '0;
        s      = e.addr[5:2];
        tag    = e.addr[13:6];
        way    = -1;
        exp_wb = 1'b0;
        if (e.op == cache_pkg::CMD_FLUSH) begin
            for (int i = 0; i < cache_pkg::SETS; i++) begin
                for (int w = 0; w < WAYS; w++) begin
                    m_valid[i][w] = 1'b0;
                    m_dirty[i][w] = 1'b0;   // Ranks stay as they are
                end
            end
            return exp;
        end
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && (m_tag[s][w] == tag)) way = w;
        end
        exp.hit = (way >= 0);
        if (way < 0) begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (m_rank[s][w] == 0) way = w;
            end
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!m_valid[s][w]) way = w;   // Lowest invalid way beats LRU
            end
            exp_wb          = m_dirty[s][way];   // Invalid lines are always clean
            m_valid[s][way] = 1'b1;
            m_tag[s][way]   = tag;
            m_dirty[s][way] = 1'b0;
        end
        touch_line(s, way);
        if (e.op == cache_pkg::CMD_WRITE) begin
            m_dirty[s][way]      = 1'b1;
            shadow[int'(e.addr)] = e.wdata;
            exp.rdata            = e.wdata;
        end else begin
            exp.rdata = shadow[int'(e.addr)];
        end
        return exp;
    endfunction

    task automatic add_cmd(cache_pkg::cache_op_e op, logic [cache_pkg::ADDR_BITS-1:0] addr);
        stim_t e;
        e.op    = op;
        e.addr  = addr;
        e.wdata = $urandom;
        e.stall = 2'($urandom_range(STALLS));
        stim_q.push_back(e);
        if (op == cache_pkg::CMD_WRITE) written_q.push_back(addr);
    endtask

    task automatic build_table();
        int n;
        // Write allocate, then hits on the same line
        add_cmd(cache_pkg::CMD_WRITE, make_addr(8'h11, 3, 0));
        add_cmd(cache_pkg::CMD_READ, make_addr(8'h11, 3, 0));
        add_cmd(cache_pkg::CMD_WRITE, make_addr(8'h11, 3, 1));
        add_cmd(cache_pkg::CMD_READ, make_addr(8'h11, 3, 1));
        // Three tags in set 3 push dirty LRU lines back to memory
        add_cmd(cache_pkg::CMD_WRITE, make_addr(8'h22, 3, 2));
        add_cmd(cache_pkg::CMD_WRITE, make_addr(8'h33, 3, 0));
        add_cmd(cache_pkg::CMD_READ, make_addr(8'h11, 3, 0));
        add_cmd(cache_pkg::CMD_READ, make_addr(8'h22, 3, 2));
        add_cmd(cache_pkg::CMD_READ, make_addr(8'h11, 3, 1));
        for (int s = 0; s < 8; s++) begin
            add_cmd(cache_pkg::CMD_WRITE, make_addr(8'h40 + s, s, s % 4));
        end
        add_cmd(cache_pkg::CMD_FLUSH, '0);
        n = written_q.size();
        for (int i = 0; i < n; i++) add_cmd(cache_pkg::CMD_READ, written_q[i]);
        // Four tags fight for two ways in a random mix on sets 5 and 6
        for (int i = 0; i < 24; i++) begin
            if ($urandom_range(1) == 0) begin
                add_cmd(cache_pkg::CMD_WRITE, make_addr(8'h50 + $urandom_range(3),
                        5 + $urandom_range(1), $urandom_range(3)));
            end else begin
                add_cmd(cache_pkg::CMD_READ, written_q[$urandom_range(written_q.size() - 1)]);
            end
        end
        add_cmd(cache_pkg::CMD_FLUSH, '0);
        n = written_q.size();
        for (int i = 0; i < n; i++) add_cmd(cache_pkg::CMD_READ, written_q[i]);
    endtask

    task automatic apply_entry(stim_t e);
        cache_pkg::cache_cmd_t c;
        cache_pkg::cache_rsp_t exp;
        cache_pkg::cache_rsp_t held;
        int                    lat;
        c.op       = e.op;
        c.addr.raw = e.addr;
        c.wdata    = e.wdata;
        exp        = predict(e);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);            // Command transfers on this edge
        cmd_valid <= 1'b0;
        lat = 0;
        @(negedge clk);
        while (!rsp_valid) begin
            check_bit("cmd_ready", 1'b0, cmd_ready);   // Busy until the result goes
            @(negedge clk);
            lat++;
        end
        check_rsp("rsp", exp, rsp);
        if (exp.hit) begin
            check_latency("hit latency", 1, lat);
        end else if (e.op != cache_pkg::CMD_FLUSH) begin
            // One memory word per cycle for the load and for any writeback
            check_min_latency("miss latency",
                              (exp_wb ? 2 : 1) * cache_pkg::WORDS_PER_LINE + 1, lat);
        end
        held = rsp;
        repeat (e.stall) begin
            @(negedge clk);
            check_rsp("rsp while stalled", held, rsp);
            check_bit("rsp_valid", 1'b1, rsp_valid);
            check_bit("cmd_ready", 1'b0, cmd_ready);
        end
        @(posedge clk);
        rsp_ready <= 1'b1;
        @(posedge clk);            // Result transfers here
        rsp_ready <= 1'b0;
        @(negedge clk);
        check_idle();
    endtask

    initial begin
        void'($urandom(80));
        clk         = 1'b0;
        rst         = 1'b1;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rsp_ready   = 1'b0;
        table_ready = 1'b0;
        for (int s = 0; s < cache_pkg::SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_rank[s][w]  = w;   // Reset rank is the way number
            end
        end
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle();
        foreach (stim_q[i]) apply_entry(stim_q[i]);
        $display("TB PASSED");
        $finish;
    end

    // Budget of 40 cycles per table entry plus reset
    initial begin
        wait (table_ready);
        repeat (16 + stim_q.size() * 40) @(posedge clk);
        $display("Watchdog expired, the cache stopped answering commands");
        stop_run();
    end

endmodule

// ==== logic/cache_controller.sv ====
`timescale 1ns/100ps

module cache_controller #(
    parameter  int WAYS     = 2,
    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1,
    localparam int LINE_ADDR_BITS = cache_pkg::INDEX_BITS + cache_pkg::OFFSET_BITS
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cmd_valid,
    input  cache_pkg::cache_cmd_t            cmd,
    output logic                             cmd_ready,
    output logic                             rsp_valid,
    output cache_pkg::cache_rsp_t            rsp,
    input  logic                             rsp_ready,
    output logic [cache_pkg::INDEX_BITS-1:0] meta_index,
    output logic [cache_pkg::TAG_BITS-1:0]   meta_tag,
    input  logic                             hit,
    input  logic [WAY_BITS-1:0]              hit_way,
    input  logic [WAY_BITS-1:0]              victim_way,
    input  logic                             victim_dirty,
    input  logic [cache_pkg::TAG_BITS-1:0]   victim_tag,
    output logic                             touch,
    output logic [WAY_BITS-1:0]              touch_way,
    output logic                             fill,
    output logic [WAY_BITS-1:0]              fill_way,
    output logic [cache_pkg::TAG_BITS-1:0]   fill_tag,
    output logic                             set_dirty,
    output logic [WAY_BITS-1:0]              dirty_way,
    output logic                             clear_dirty,
    output logic [WAY_BITS-1:0]              clear_way,
    output logic                             invalidate_all,
    output logic                             sel_index,
    output logic                             ram0_en,
    output logic                             ram0_we,
    output logic [WAY_BITS-1:0]              ram0_way,
    output logic [LINE_ADDR_BITS-1:0]        ram0_addr,
    output logic [cache_pkg::DATA_BITS-1:0]  ram0_wdata,
    input  logic [cache_pkg::DATA_BITS-1:0]  ram0_rdata,
    output logic                             ram1_en,
    output logic                             ram1_we,
    output logic [WAY_BITS-1:0]              ram1_way,
    output logic [LINE_ADDR_BITS-1:0]        ram1_addr,
    output logic [cache_pkg::DATA_BITS-1:0]  ram1_wdata,
    input  logic [cache_pkg::DATA_BITS-1:0]  ram1_rdata,
    output cache_pkg::mem_req_t              mem_req,
    input  logic [cache_pkg::DATA_BITS-1:0]  mem_rdata
);

    typedef enum logic [2:0] {
        ST_NORMAL,   // Idle, or looking up the held command
        ST_STORE,    // Victim line back to memory
        ST_LOAD,     // New line in from memory
        ST_FLUSH,    // Walk every set and way
        ST_RESPOND   // Result held until taken
    } state_e;

    state_e                           state;
    cache_pkg::cache_cmd_t            cmd_q;
    cache_pkg::cache_addr_u           line_addr;
    logic                             busy_q;      // Command held for lookup
    logic                             flushing_q;
    logic [1:0]                       cnt;         // Word counter
    logic                             last_q;      // All four words issued
    logic                             pend_q;      // One word in flight
    logic [1:0]                       pend_off;    // Its offset
    logic [WAY_BITS-1:0]              way_q;
    logic [cache_pkg::INDEX_BITS-1:0] flush_set;
    logic [WAY_BITS-1:0]              flush_way;
    logic                             hit_q;
    logic                             from_ram_q;  // Read hit data comes from port 0
    logic [cache_pkg::DATA_BITS-1:0]  rdata_q;
    logic [cache_pkg::DATA_BITS-1:0]  fill_word;
    logic                             is_write, lookup, line_done, flush_last;

    assign is_write   = (cmd_q.op == cache_pkg::CMD_WRITE);
    assign lookup     = (state == ST_NORMAL) && busy_q && (cmd_q.op != cache_pkg::CMD_FLUSH);
    assign line_done  = pend_q && (pend_off == 2'd3);
    assign flush_last = (flush_way == WAY_BITS'(WAYS - 1)) && (flush_set == '1);

    assign cmd_ready = (state == ST_NORMAL) && !busy_q;
    assign rsp_valid = (state == ST_RESPOND);
    assign rsp.hit   = hit_q;
    assign rsp.rdata = from_ram_q ? ram0_rdata : rdata_q;

    // Metadata, flush walks its own set and way
    assign meta_index     = flushing_q ? flush_set : cmd_q.addr.fields.index;
    assign meta_tag       = cmd_q.addr.fields.tag;
    assign sel_index      = flushing_q;
    assign fill           = (state == ST_LOAD) && line_done;
    assign fill_way       = way_q;
    assign fill_tag       = cmd_q.addr.fields.tag;
    assign touch          = (lookup && hit) || fill;
    assign touch_way      = (state == ST_LOAD) ? way_q : hit_way;
    assign set_dirty      = is_write && ((lookup && hit) || fill);
    assign dirty_way      = touch_way;
    assign clear_dirty    = (state == ST_STORE) && line_done && flushing_q;
    assign clear_way      = flush_way;
    assign invalidate_all = (state == ST_FLUSH) && !victim_dirty && flush_last;

    assign ram0_en    = lookup && hit;
    assign ram0_we    = is_write;
    assign ram0_way   = hit_way;
    assign ram0_addr  = {cmd_q.addr.fields.index, cmd_q.addr.fields.offset};
    assign ram0_wdata = cmd_q.wdata;

    // Write miss merges its word into the incoming line
    assign fill_word  = (is_write && (pend_off == cmd_q.addr.fields.offset)) ?
                        cmd_q.wdata : mem_rdata;
    assign ram1_en    = ((state == ST_STORE) && !last_q) || ((state == ST_LOAD) && pend_q);
    assign ram1_we    = (state == ST_LOAD);
    assign ram1_way   = way_q;
    assign ram1_addr  = {meta_index, (state == ST_STORE) ? cnt : pend_off};
    assign ram1_wdata = fill_word;

    // Store writes the word read last cycle, load reads ahead of the fill
    always_comb begin
        line_addr.fields.tag    = (state == ST_STORE) ? victim_tag : cmd_q.addr.fields.tag;
        line_addr.fields.index  = meta_index;
        line_addr.fields.offset = (state == ST_STORE) ? pend_off : cnt;
        mem_req.valid = ((state == ST_STORE) && pend_q) || ((state == ST_LOAD) && !last_q);
        mem_req.write = (state == ST_STORE);
        mem_req.addr  = line_addr.raw;
        mem_req.wdata = ram1_rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_NORMAL;
            busy_q     <= 1'b0;
            flushing_q <= 1'b0;
            cnt        <= '0;
            last_q     <= 1'b0;
            pend_q     <= 1'b0;
            flush_set  <= '0;
            flush_way  <= '0;
        end else begin
            case (state)
                ST_NORMAL: begin
                    if (!busy_q) begin
                        busy_q <= cmd_valid;
                    end else if (cmd_q.op == cache_pkg::CMD_FLUSH) begin
                        state      <= ST_FLUSH;
                        flushing_q <= 1'b1;
                        flush_set  <= '0;
                        flush_way  <= '0;
                    end else if (hit) begin
                        state <= ST_RESPOND;
                    end else begin
                        state <= victim_dirty ? ST_STORE : ST_LOAD;
                    end
                end
                ST_STORE, ST_LOAD: begin
                    if (!last_q) begin
                        cnt    <= cnt + 2'd1;   // Wraps back to 0 after word 3
                        last_q <= (cnt == 2'd3);
                    end
                    pend_q <= !last_q;
                    if (line_done) begin
                        last_q <= 1'b0;
                        pend_q <= 1'b0;
                        if (state == ST_LOAD) begin
                            state <= ST_RESPOND;
                        end else begin
                            state <= flushing_q ? ST_FLUSH : ST_LOAD;
                        end
                    end
                end
                ST_FLUSH: begin
                    if (victim_dirty) begin
                        state <= ST_STORE;          // Comes back here with the line clean
                    end else if (flush_way == WAY_BITS'(WAYS - 1)) begin
                        flush_way <= '0;
                        flush_set <= flush_set + 1'b1;
                        if (flush_last) begin
                            state      <= ST_RESPOND;
                            flushing_q <= 1'b0;
                        end
                    end else begin
                        flush_way <= flush_way + 1'b1;
                    end
                end
                ST_RESPOND: begin
                    if (rsp_ready) begin
                        state  <= ST_NORMAL;
                        busy_q <= 1'b0;
                    end
                end
                default: state <= ST_NORMAL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_ready && cmd_valid) begin
            cmd_q <= cmd;
        end
        pend_off <= cnt;
        if ((state == ST_NORMAL) || (state == ST_FLUSH)) begin
            way_q <= victim_way;  // Held through store and load
        end
        if ((state == ST_NORMAL) && busy_q) begin
            hit_q      <= lookup && hit;
            from_ram_q <= lookup && hit && !is_write;
            rdata_q    <= lookup ? cmd_q.wdata : '0;  // Flush answers with zero
        end
        if ((state == ST_LOAD) && pend_q && (pend_off == cmd_q.addr.fields.offset)) begin
            rdata_q <= fill_word;
        end
    end

    assert property (@(posedge clk) disable iff (rst) (state == ST_NORMAL) |-> !mem_req.valid);
    assert property (@(posedge clk) disable iff (rst) !(cmd_ready && rsp_valid));

endmodule

// ==== logic/cache_data_ram.sv ====
`timescale 1ns/100ps

module cache_data_ram #(
    parameter  int WAYS     = 2,
    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1,
    localparam int LINE_ADDR_BITS = cache_pkg::INDEX_BITS + cache_pkg::OFFSET_BITS
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ram0_en,
    input  logic                            ram0_we,
    input  logic [WAY_BITS-1:0]             ram0_way,
    input  logic [LINE_ADDR_BITS-1:0]       ram0_addr,   // {index, offset}
    input  logic [cache_pkg::DATA_BITS-1:0] ram0_wdata,
    output logic [cache_pkg::DATA_BITS-1:0] ram0_rdata,
    input  logic                            ram1_en,
    input  logic                            ram1_we,
    input  logic [WAY_BITS-1:0]             ram1_way,
    input  logic [LINE_ADDR_BITS-1:0]       ram1_addr,
    input  logic [cache_pkg::DATA_BITS-1:0] ram1_wdata,
    output logic [cache_pkg::DATA_BITS-1:0] ram1_rdata
);

    localparam int DEPTH = WAYS * cache_pkg::SETS * cache_pkg::WORDS_PER_LINE;

    logic [cache_pkg::DATA_BITS-1:0] mem_q [DEPTH];
    logic [WAY_BITS+LINE_ADDR_BITS-1:0] loc0, loc1;

    assign loc0 = {ram0_way, ram0_addr};  // Way selects the bank
    assign loc1 = {ram1_way, ram1_addr};

    // Contents hold across reset, only writes are blocked
    always_ff @(posedge clk) begin
        if (ram0_en) begin
            if (ram0_we && !rst) begin
                mem_q[loc0] <= ram0_wdata;
            end
            ram0_rdata <= mem_q[loc0];  // Read before write
        end
        if (ram1_en) begin
            if (ram1_we && !rst) begin
                mem_q[loc1] <= ram1_wdata;
            end
            ram1_rdata <= mem_q[loc1];
        end
    end

    // Hits and line transfers never overlap in the controller
    assert property (@(posedge clk) disable iff (rst)
        !(ram0_en && ram0_we && ram1_en && ram1_we && (loc0 == loc1)));

endmodule

// ==== logic/cache_meta_store.sv ====
`timescale 1ns/100ps

module cache_meta_store #(
    parameter  int WAYS     = 2,
    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cache_pkg::INDEX_BITS-1:0] meta_index,
    input  logic [cache_pkg::TAG_BITS-1:0]   meta_tag,
    output logic                             hit,
    output logic [WAY_BITS-1:0]              hit_way,
    output logic [WAY_BITS-1:0]              victim_way,
    output logic                             victim_dirty,
    output logic [cache_pkg::TAG_BITS-1:0]   victim_tag,
    input  logic                             touch,
    input  logic [WAY_BITS-1:0]              touch_way,
    input  logic                             fill,
    input  logic [WAY_BITS-1:0]              fill_way,
    input  logic [cache_pkg::TAG_BITS-1:0]   fill_tag,
    input  logic                             set_dirty,
    input  logic [WAY_BITS-1:0]              dirty_way,
    input  logic                             clear_dirty,
    input  logic [WAY_BITS-1:0]              clear_way,
    input  logic                             invalidate_all,
    input  logic                             sel_index   // Inspect clear_way, not the LRU pick
);

    logic                           valid_q [cache_pkg::SETS][WAYS];
    logic                           dirty_q [cache_pkg::SETS][WAYS];
    logic [cache_pkg::TAG_BITS-1:0] tag_q   [cache_pkg::SETS][WAYS];
    logic [WAY_BITS-1:0]            rank_q  [cache_pkg::SETS][WAYS];  // 0 is least recent
    logic [WAYS-1:0]                hit_vec;
    logic [WAY_BITS-1:0]            lru_way;
    logic [WAY_BITS-1:0]            free_way;
    logic                           free_found;

    // Tag compare across the indexed set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_q[meta_index][w] && (tag_q[meta_index][w] == meta_tag);
            if (hit_vec[w]) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    // Lowest invalid way first, else the rank 0 way
    always_comb begin
        lru_way    = '0;
        free_way   = '0;
        free_found = 1'b0;
        for (int w = WAYS - 1; w >= 0; w--) begin  // Descending so lowest wins
            if (rank_q[meta_index][w] == '0) begin
                lru_way = WAY_BITS'(w);
            end
            if (!valid_q[meta_index][w]) begin
                free_found = 1'b1;
                free_way   = WAY_BITS'(w);
            end
        end
        if (sel_index) begin
            victim_way = clear_way;                // Flush walk picks the line itself
        end else begin
            victim_way = free_found ? free_way : lru_way;
        end
    end

    assign victim_dirty = dirty_q[meta_index][victim_way];
    assign victim_tag   = tag_q[meta_index][victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                    rank_q[s][w]  <= WAY_BITS'(w);  // Rank starts as way number
                end
            end
        end else if (invalidate_all) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                end
            end
        end else begin
            if (fill) begin
                valid_q[meta_index][fill_way] <= 1'b1;
                dirty_q[meta_index][fill_way] <= 1'b0;  // Clean unless set_dirty below
            end
            if (set_dirty) begin
                dirty_q[meta_index][dirty_way] <= 1'b1;  // Write miss marks its fresh line
            end
            if (clear_dirty) begin
                dirty_q[meta_index][clear_way] <= 1'b0;
            end
            if (touch) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (WAY_BITS'(w) == touch_way) begin
                        rank_q[meta_index][w] <= WAY_BITS'(WAYS - 1);
                    end else if (rank_q[meta_index][w] > rank_q[meta_index][touch_way]) begin
                        rank_q[meta_index][w] <= rank_q[meta_index][w] - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[meta_index][fill_way] <= fill_tag;
        end
    end

    // Fills only follow a miss on the same tag, so a tag never sits in two ways
    assert property (@(posedge clk) disable iff (rst) $countones(hit_vec) <= 1);

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    localparam int DATA_BITS      = 32;
    localparam int ADDR_BITS      = 14;
    localparam int TAG_BITS       = 8;
    localparam int INDEX_BITS     = 4;
    localparam int OFFSET_BITS    = 2;
    localparam int WORDS_PER_LINE = 4;
    localparam int SETS           = 16;

    // Word address split, tag in the top bits
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;   // Set select
        logic [OFFSET_BITS-1:0] offset;  // Word within the line
    } cache_addr_fields_t;

    typedef union packed {
        logic [ADDR_BITS-1:0] raw;     // As the memory sees it
        cache_addr_fields_t   fields;  // As the cache sees it
    } cache_addr_u;

    typedef enum logic [1:0] {
        CMD_READ,
        CMD_WRITE,
        CMD_FLUSH   // Write back every dirty line, then invalidate all
    } cache_op_e;

    typedef struct packed {
        cache_op_e            op;
        cache_addr_u          addr;
        logic [DATA_BITS-1:0] wdata;
    } cache_cmd_t;

    typedef struct packed {
        logic                 hit;
        logic [DATA_BITS-1:0] rdata;  // Zero for a flush
    } cache_rsp_t;

    // One strobe per word, memory never stalls
    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] wdata;
    } mem_req_t;

endpackage

// ==== logic/cache_top.sv ====
`timescale 1ns/100ps

module cache_top #(
    parameter int WAYS = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  cache_pkg::cache_cmd_t cmd,
    output logic                  cmd_ready,
    output logic                  rsp_valid,
    output cache_pkg::cache_rsp_t rsp,
    input  logic                  rsp_ready
);

    localparam int WAY_BITS  = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int LINE_BITS = cache_pkg::INDEX_BITS + cache_pkg::OFFSET_BITS;

    logic [cache_pkg::INDEX_BITS-1:0] meta_index;
    logic [cache_pkg::TAG_BITS-1:0]   meta_tag, victim_tag, fill_tag;
    logic [WAY_BITS-1:0]              hit_way, victim_way, touch_way, fill_way;
    logic [WAY_BITS-1:0]              dirty_way, clear_way;
    logic                             hit, victim_dirty, touch, fill, set_dirty;
    logic                             clear_dirty, invalidate_all, sel_index;
    logic                             ram0_en, ram0_we, ram1_en, ram1_we;
    logic [WAY_BITS-1:0]              ram0_way, ram1_way;
    logic [LINE_BITS-1:0]             ram0_addr, ram1_addr;
    logic [cache_pkg::DATA_BITS-1:0]  ram0_wdata, ram0_rdata, ram1_wdata, ram1_rdata;
    cache_pkg::mem_req_t              mem_req;
    logic [cache_pkg::DATA_BITS-1:0]  mem_rdata;

    cache_controller #(.WAYS(WAYS)) u_ctrl (
        .clk, .rst,
        .cmd_valid, .cmd, .cmd_ready,
        .rsp_valid, .rsp, .rsp_ready,
        .meta_index, .meta_tag,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .touch, .touch_way, .fill, .fill_way, .fill_tag,
        .set_dirty, .dirty_way, .clear_dirty, .clear_way,
        .invalidate_all, .sel_index,
        .ram0_en, .ram0_we, .ram0_way, .ram0_addr, .ram0_wdata, .ram0_rdata,
        .ram1_en, .ram1_we, .ram1_way, .ram1_addr, .ram1_wdata, .ram1_rdata,
        .mem_req, .mem_rdata
    );

    cache_meta_store #(.WAYS(WAYS)) u_meta (
        .clk, .rst,
        .meta_index, .meta_tag,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .touch, .touch_way, .fill, .fill_way, .fill_tag,
        .set_dirty, .dirty_way, .clear_dirty, .clear_way,
        .invalidate_all, .sel_index
    );

    cache_data_ram #(.WAYS(WAYS)) u_data (
        .clk, .rst,
        .ram0_en, .ram0_we, .ram0_way, .ram0_addr, .ram0_wdata, .ram0_rdata,
        .ram1_en, .ram1_we, .ram1_way, .ram1_addr, .ram1_wdata, .ram1_rdata
    );

    main_memory u_mem (
        .clk,
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

// ==== logic/main_memory.sv ====
`timescale 1ns/100ps

module main_memory (
    input  logic                            clk,
    input  cache_pkg::mem_req_t             req,
    output logic [cache_pkg::DATA_BITS-1:0] rdata
);

    logic [cache_pkg::DATA_BITS-1:0] mem_q [2**cache_pkg::ADDR_BITS];

    // Write lands at the strobe edge, read data the cycle after
    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.write) begin
                mem_q[req.addr] <= req.wdata;
            end else begin
                rdata <= mem_q[req.addr];
            end
        end
    end

endmodule

// ==== verilog.f ====
logic/cache_pkg.sv
logic/cache_meta_store.sv
logic/cache_data_ram.sv
logic/cache_controller.sv
logic/main_memory.sv
logic/cache_top.sv
dv/tb_cache_top.sv
